/* hdl/esc_pkg.sv */
// shared constants, word types and FSM states for the escape-coded tlast link, import where needed
package esc_pkg;

   localparam int WORD_W       = 64;                    // stream and link word
   localparam int CSUM_W       = 32;                    // running xor checksum
   localparam int LINK_CREDITS = 4;                     // rx buffer depth = initial credits
   localparam int CREDIT_W     = $clog2(LINK_CREDITS + 1);
   localparam int BUF_PTR_W    = (LINK_CREDITS > 1) ? $clog2(LINK_CREDITS) : 1;

   localparam logic [WORD_W-1:0] ESC_CODE = 64'hDEADBEEFFEEDCAFE; // in-band escape

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [CSUM_W-1:0]    csum_t;
   typedef logic [CREDIT_W-1:0]  credit_t;   // holds 0..LINK_CREDITS
   typedef logic [BUF_PTR_W-1:0] buf_ptr_t;  // rx buffer slot index

   // sender side: escape, flag, then the data word itself
   typedef enum logic [1:0] {
      ENC_IDLE,
      ENC_FLAG,
      ENC_DATA
   } enc_state_t;

   // receiver side mirrors the encoder
   typedef enum logic [1:0] {
      DEC_IDLE,
      DEC_FLAG,
      DEC_DATA
   } dec_state_t;

   // checksum contribution of one word, both halves folded
   function automatic csum_t word_csum(input word_t w);
      return w[WORD_W-1:CSUM_W] ^ w[CSUM_W-1:0];
   endfunction

endpackage

/* hdl/esc_link_if.sv */
// word link with credit return, sender pushes words, receiver hands back one credit per pop
interface esc_link_if;
   import esc_pkg::*;

   word_t word;    // link word, meaningful while valid
   logic  valid;   // one word per cycle, only with a credit in hand
   logic  credit;  // single-cycle pulse, one slot freed

   // encoder side, or buffer output side
   modport sender (
      output word,
      output valid,
      input  credit
   );

   // buffer input side, or decoder side
   modport receiver (
      input  word,
      input  valid,
      output credit
   );

endinterface

/* hdl/esc_encoder.sv */
// escape encoder that turns a tlast stream into plain link words and spends link credits
module esc_encoder (
   input  logic           clk,
   input  logic           i_reset,
   input  esc_pkg::word_t i_tdata,
   input  logic           i_tlast,
   input  logic           i_tvalid,
   output logic           o_tready,
   esc_link_if.sender     link
);
   import esc_pkg::*;

   enc_state_t state;
   enc_state_t state_nxt;
   credit_t    credits;     // free slots at the far buffer
   csum_t      csum;        // xor of accepted non-last words
   logic       flag_last;   // escape belongs to a last word
   logic       has_credit;
   logic       need_esc;    // word needs the three word sequence
   logic       send;        // link word goes out this cycle
   logic       accept;      // input word consumed this cycle

   assign has_credit = (credits != '0);
   assign need_esc   = i_tlast || (i_tdata == ESC_CODE);

   always_comb begin
      state_nxt = state;
      link.word = i_tdata;   // pass through by default
      send      = 1'b0;
      accept    = 1'b0;
      case (state)
         ENC_IDLE: begin
            if (i_tvalid && has_credit) begin
               send = 1'b1;
               if (need_esc) begin
                  link.word = ESC_CODE;  // input held until the data cycle
                  state_nxt = ENC_FLAG;
               end else begin
                  accept = 1'b1;         // plain word goes straight through
               end
            end
         end
         ENC_FLAG: begin
            // 1 with checksum marks end of packet and 0 marks escaped data
            link.word = flag_last ? {csum, CSUM_W'(1)} : '0;
            if (has_credit) begin
               send      = 1'b1;
               state_nxt = ENC_DATA;
            end
         end
         ENC_DATA: begin
            if (i_tvalid && has_credit) begin
               send      = 1'b1;
               accept    = 1'b1;
               state_nxt = ENC_IDLE;
            end
         end
         default: state_nxt = ENC_IDLE;
      endcase
   end

   assign link.valid = send;
   assign o_tready   = accept;  // low through escape and flag cycles

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state     <= ENC_IDLE;
         flag_last <= 1'b0;
         csum      <= '0;
      end else begin
         state <= state_nxt;
         if (state == ENC_IDLE && send && need_esc) begin
            flag_last <= i_tlast;  // decides the flag word
         end
         if (accept) begin
            if (state == ENC_DATA && flag_last) begin
               csum <= '0;  // packet done
            end else begin
               csum <= csum ^ word_csum(i_tdata);
            end
         end
      end
   end

   // credits spent on send and refilled on each receiver pulse
   always_ff @(posedge clk) begin
      if (i_reset) begin
         credits <= credit_t'(LINK_CREDITS);
      end else begin
         case ({send, link.credit})
            2'b10:   credits <= credits - credit_t'(1);
            2'b01:   credits <= credits + credit_t'(1);
            default: credits <= credits;  // idle or spend and refill together
         endcase
      end
   end

   // receiver never returns more than it was given
   a_credit_max: assert property (@(posedge clk) disable iff (i_reset)
      credits <= credit_t'(LINK_CREDITS))
      else $error("link credits above buffer depth");

endmodule

/* hdl/credit_buffer.sv */
// receive FIFO at the link end, head shown downstream, one credit returned per pop
module credit_buffer (
   input  logic         clk,
   input  logic         i_reset,
   esc_link_if.receiver link_in,
   esc_link_if.sender   link_out
);
   import esc_pkg::*;

   word_t    mem [LINK_CREDITS];  // payload only
   buf_ptr_t wr_ptr;
   buf_ptr_t rd_ptr;
   credit_t  count;               // words held
   logic     push;
   logic     pop;

   // circular increment, depth need not be a power of two
   function automatic buf_ptr_t ptr_inc(input buf_ptr_t p);
      if (p == buf_ptr_t'(LINK_CREDITS - 1)) begin
         return '0;
      end
      return p + buf_ptr_t'(1);
   endfunction

   assign push = link_in.valid;                  // credit rule, always room
   assign pop  = link_out.credit && (count != '0);

   assign link_out.word  = mem[rd_ptr];          // head word
   assign link_out.valid = (count != '0);
   assign link_in.credit = pop;                  // slot freed, same cycle

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= link_in.word;
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + credit_t'(1);
            2'b01:   count <= count - credit_t'(1);
            default: count <= count;
         endcase
      end
   end

   // sender credit count must track free slots here
   a_no_overflow: assert property (@(posedge clk) disable iff (i_reset)
      push |-> count != credit_t'(LINK_CREDITS))
      else $error("link word written into full buffer");

endmodule

/* hdl/esc_decoder.sv */
// escape decoder, strips escape sequences, restores tlast and checks per-packet checksum
module esc_decoder (
   input  logic           clk,
   input  logic           i_reset,
   esc_link_if.receiver   link,
   output esc_pkg::word_t o_tdata,
   output logic           o_tlast,
   output logic           o_tvalid,
   output logic           o_checksum_error,
   input  logic           i_tready
);
   import esc_pkg::*;

   dec_state_t state;
   dec_state_t state_nxt;
   csum_t      csum;       // own xor of delivered non-last words
   logic       last_pend;  // tlast for the word after the flag
   logic       pop;        // head consumed, doubles as credit
   logic       take_flag;
   logic       take_data;
   logic       csum_bad;

   assign o_tdata = link.word;  // straight from buffer head

   always_comb begin
      state_nxt = state;
      o_tvalid  = 1'b0;
      o_tlast   = 1'b0;
      pop       = 1'b0;
      take_flag = 1'b0;
      take_data = 1'b0;
      case (state)
         DEC_IDLE: begin
            if (link.valid) begin
               if (link.word == ESC_CODE) begin
                  pop       = 1'b1;  // swallowed
                  state_nxt = DEC_FLAG;
               end else begin
                  o_tvalid = 1'b1;   // ordinary word, tlast low
                  if (i_tready) begin
                     pop       = 1'b1;
                     take_data = 1'b1;
                  end
               end
            end
         end
         DEC_FLAG: begin
            if (link.valid) begin
               pop       = 1'b1;  // flag never reaches output
               take_flag = 1'b1;
               state_nxt = DEC_DATA;
            end
         end
         DEC_DATA: begin
            if (link.valid) begin
               o_tvalid = 1'b1;  // may itself equal ESC_CODE
               o_tlast  = last_pend;
               if (i_tready) begin
                  pop       = 1'b1;
                  take_data = 1'b1;
                  state_nxt = DEC_IDLE;
               end
            end
         end
         default: state_nxt = DEC_IDLE;
      endcase
   end

   assign link.credit = pop;

   // only end-of-packet flags carry a checksum
   assign csum_bad = link.word[0] && (link.word[WORD_W-1:CSUM_W] != csum);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state            <= DEC_IDLE;
         csum             <= '0;
         last_pend        <= 1'b0;
         o_checksum_error <= 1'b0;
      end else begin
         state            <= state_nxt;
         o_checksum_error <= take_flag && csum_bad;  // one cycle pulse
         if (take_flag) begin
            last_pend <= link.word[0];
         end
         if (take_data) begin
            csum <= o_tlast ? '0 : csum ^ word_csum(link.word);
         end
      end
   end

   // encoder only ever emits 0 or 1 in the flag low half
   a_flag_low: assert property (@(posedge clk) disable iff (i_reset)
      (state == DEC_FLAG && link.valid) |-> link.word[CSUM_W-1:1] == '0)
      else $error("malformed flag word on link");

endmodule

/* hdl/tlast_link.sv */
// top level, stream in, escape coded credit link, stream out with restored tlast
module tlast_link (
   input  logic           clk,
   input  logic           i_reset,
   // upstream stream
   input  esc_pkg::word_t i_tdata,
   input  logic           i_tlast,
   input  logic           i_tvalid,
   output logic           o_tready,
   // downstream stream
   output esc_pkg::word_t o_tdata,
   output logic           o_tlast,
   output logic           o_tvalid,
   output logic           o_checksum_error,
   input  logic           i_tready
);

   esc_link_if link_enc ();  // encoder to buffer
   esc_link_if link_buf ();  // buffer head to decoder

   esc_encoder esc_encoder_i (
      .clk      (clk),
      .i_reset  (i_reset),
      .i_tdata  (i_tdata),
      .i_tlast  (i_tlast),
      .i_tvalid (i_tvalid),
      .o_tready (o_tready),
      .link     (link_enc)
   );

   credit_buffer credit_buffer_i (
      .clk      (clk),
      .i_reset  (i_reset),
      .link_in  (link_enc),
      .link_out (link_buf)
   );

   esc_decoder esc_decoder_i (
      .clk              (clk),
      .i_reset          (i_reset),
      .link             (link_buf),
      .o_tdata          (o_tdata),
      .o_tlast          (o_tlast),
      .o_tvalid         (o_tvalid),
      .o_checksum_error (o_checksum_error),
      .i_tready         (i_tready)   // decoder pops feed back as credits
   );

endmodule

/* tests/tb_tlast_link.sv */
// directed testbench for tlast_link that sends packets and checks words and tlast at the output
module tb_tlast_link;
   import esc_pkg::*;

   localparam int HALF_PERIOD  = 10;
   localparam int SEND_TIMEOUT = 500;   // cycles allowed per input word
   localparam int RECV_TIMEOUT = 2000;  // cycles allowed for a whole test to drain
   localparam int DRAIN_CYCLES = 4 * LINK_CREDITS;  // room for a full buffer to empty

   logic  clk;
   logic  i_reset;
   word_t i_tdata;
   logic  i_tlast;
   logic  i_tvalid;
   logic  o_tready;
   word_t o_tdata;
   logic  o_tlast;
   logic  o_tvalid;
   logic  o_checksum_error;
   logic  i_tready;

   word_t tx_data[$];   // words to drive in order
   logic  tx_last[$];
   word_t exp_data[$];  // output equals input word for word
   logic  exp_last[$];
   word_t rx_data[$];   // filled by the monitor
   logic  rx_last[$];

   int error_count;
   int check_count;
   int test_count;
   int failed_tests;
   int test_errors;     // errors in the running test
   int csum_errors;     // o_checksum_error pulses in the running test

   tlast_link tlast_link_i (
      .clk              (clk),
      .i_reset          (i_reset),
      .i_tdata          (i_tdata),
      .i_tlast          (i_tlast),
      .i_tvalid         (i_tvalid),
      .o_tready         (o_tready),
      .o_tdata          (o_tdata),
      .o_tlast          (o_tlast),
      .o_tvalid         (o_tvalid),
      .o_checksum_error (o_checksum_error),
      .i_tready         (i_tready)
   );

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   task automatic check_value(input string test, input string what,
                              input logic [63:0] expected, input logic [63:0] actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         test_errors++;
         $display("CHECK FAILED %s %s: expected %h actual %h", test, what, expected, actual);
      end
   endtask

   task automatic report_problem(input string test, input string msg);
      error_count++;
      test_errors++;
      $display("ERROR %s: %s", test, msg);
   endtask

   // random payload that never equals the escape code
   function automatic word_t random_word();
      word_t w;
      w = {$urandom, $urandom};
      while (w == ESC_CODE) begin
         w = {$urandom, $urandom};
      end
      return w;
   endfunction

   task automatic add_word(input word_t data, input logic last);
      tx_data.push_back(data);
      tx_last.push_back(last);
      exp_data.push_back(data);  // escapes are invisible at the output
      exp_last.push_back(last);
   endtask

   task automatic start_test();
      tx_data.delete();
      tx_last.delete();
      exp_data.delete();
      exp_last.delete();
      rx_data.delete();
      rx_last.delete();
      test_errors = 0;
      csum_errors = 0;
      test_count++;
   endtask

   task automatic end_test(input string test);
      if (test_errors == 0) begin
         $display("test %s: ok, %0d words", test, exp_data.size());
      end else begin
         failed_tests++;
         $display("test %s: %0d errors", test, test_errors);
      end
   endtask

   // outputs sampled at the rising edge while inputs move on the falling one
   task automatic watch_output();
      forever begin
         @(posedge clk);
         if (o_tvalid && i_tready) begin
            rx_data.push_back(o_tdata);
            rx_last.push_back(o_tlast);
         end
         if (o_checksum_error) csum_errors++;
      end
   endtask

   task automatic send_all(input string test);
      int  i;
      int  waited;
      logic stuck;
      stuck = 1'b0;
      for (i = 0; i < tx_data.size() && !stuck; i++) begin
         @(negedge clk);
         i_tdata  = tx_data[i];
         i_tlast  = tx_last[i];
         i_tvalid = 1'b1;
         waited   = 0;
         @(posedge clk);
         while (!o_tready && waited < SEND_TIMEOUT) begin  // escape cycles and stalls
            waited++;
            @(posedge clk);
         end
         if (!o_tready) begin
            report_problem(test, $sformatf("input word %0d was never accepted", i));
            stuck = 1'b1;
         end
      end
      @(negedge clk);
      i_tvalid = 1'b0;
      i_tlast  = 1'b0;
   endtask

   task automatic wait_received(input string test);
      int waited;
      int quiet;
      waited = 0;
      while (rx_data.size() < exp_data.size() && waited < RECV_TIMEOUT) begin
         @(negedge clk);  // away from monitor pushes
         waited++;
      end
      if (rx_data.size() < exp_data.size()) begin
         report_problem(test, $sformatf("only %0d of %0d words came out before timeout",
                                        rx_data.size(), exp_data.size()));
      end
      // duplicated or stray words would surface here
      for (quiet = 0; quiet < DRAIN_CYCLES; quiet++) begin
         @(negedge clk);
      end
   endtask

   task automatic compare_all(input string test);
      int i;
      check_value(test, "word count", exp_data.size(), rx_data.size());
      for (i = 0; i < exp_data.size() && i < rx_data.size(); i++) begin
         check_value(test, $sformatf("word %0d tdata", i), exp_data[i], rx_data[i]);
         check_value(test, $sformatf("word %0d tlast", i), exp_last[i], rx_last[i]);
      end
      check_value(test, "checksum error pulses", 0, csum_errors);  // link is lossless
   endtask

   // sink held off until the buffer fills and the encoder stalls
   task automatic stall_output(input string test, input int cycles);
      int i;
      int accepted;
      accepted = 0;
      @(negedge clk);
      i_tready = 1'b0;
      for (i = 0; i < cycles; i++) begin
         @(posedge clk);
         if (i_tvalid && o_tready) accepted++;
      end
      check_value(test, "o_tready at end of stall", 0, o_tready);
      check_value(test, "words taken during stall", LINK_CREDITS, accepted);  // buffer depth
      @(negedge clk);
      i_tready = 1'b1;
   endtask

   task automatic test_reset_state();
      start_test();
      check_value("reset_state", "o_tready", 0, o_tready);
      check_value("reset_state", "o_tvalid", 0, o_tvalid);
      check_value("reset_state", "o_checksum_error", 0, o_checksum_error);
      end_test("reset_state");
   endtask

   task automatic test_plain_packets();
      int p;
      int i;
      start_test();
      for (p = 0; p < 2; p++) begin
         for (i = 0; i < 10; i++) add_word(random_word(), i == 9);
      end
      send_all("plain_packets");
      wait_received("plain_packets");
      compare_all("plain_packets");
      end_test("plain_packets");
   endtask

   task automatic test_escaped_data();
      int i;
      start_test();
      for (i = 0; i < 9; i++) begin
         if (i == 0 || i == 3 || i == 4) add_word(ESC_CODE, 1'b0);  // two back to back
         else add_word(random_word(), i == 8);
      end
      send_all("escaped_data");
      wait_received("escaped_data");
      compare_all("escaped_data");
      end_test("escaped_data");
   endtask

   task automatic test_escape_last();
      int i;
      start_test();
      for (i = 0; i < 5; i++) add_word(random_word(), 1'b0);
      add_word(ESC_CODE, 1'b1);
      for (i = 0; i < 3; i++) add_word(random_word(), i == 2);  // checksum restarts
      send_all("escape_last");
      wait_received("escape_last");
      compare_all("escape_last");
      end_test("escape_last");
   endtask

   task automatic test_single_words();
      int i;
      start_test();
      for (i = 0; i < 6; i++) begin
         if (i == 3) add_word(ESC_CODE, 1'b1);
         else add_word(random_word(), 1'b1);
      end
      send_all("single_words");
      wait_received("single_words");
      compare_all("single_words");
      end_test("single_words");
   endtask

   task automatic test_back_pressure();
      int i;
      int stall;
      start_test();
      stall = $urandom_range(60, 20);
      for (i = 0; i < 24; i++) begin
         if (i == 12) add_word(ESC_CODE, 1'b0);
         else add_word(random_word(), i == 23);
      end
      fork
         send_all("back_pressure");
         stall_output("back_pressure", stall);
      join
      wait_received("back_pressure");
      compare_all("back_pressure");
      end_test("back_pressure");
   endtask

   initial begin
      void'($urandom(32'h27e6d33e));  // one seed for the whole run
      i_reset      = 1'b1;
      i_tdata      = '0;
      i_tlast      = 1'b0;
      i_tvalid     = 1'b0;
      i_tready     = 1'b1;  // sink ready unless a test stalls it
      error_count  = 0;
      check_count  = 0;
      test_count   = 0;
      failed_tests = 0;
      test_errors  = 0;
      csum_errors  = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      i_reset = 1'b0;
      fork
         watch_output();
      join_none
      test_reset_state();
      test_plain_packets();
      test_escaped_data();
      test_escape_last();
      test_single_words();
      test_back_pressure();
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_count, failed_tests, check_count, error_count);
      if (error_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* tb.f */
hdl/esc_pkg.sv
hdl/esc_link_if.sv
hdl/esc_encoder.sv
hdl/credit_buffer.sv
hdl/esc_decoder.sv
hdl/tlast_link.sv
tests/tb_tlast_link.sv

/* Bender.yml */
package:
  name: tlast_link

sources:
  - hdl/esc_pkg.sv
  - hdl/esc_link_if.sv
  - hdl/esc_encoder.sv
  - hdl/credit_buffer.sv
  - hdl/esc_decoder.sv
  - hdl/tlast_link.sv
  - target: test
    files:
      - tests/tb_tlast_link.sv
